// File: flist.f
hdl/bp_pkg.sv
hdl/branch_history_table.sv
hdl/branch_target_buffer.sv
hdl/dynamic_branch_predictor.sv
hdl/branch_resolver.sv
hdl/fetch_unit.sv
hdl/bp_top.sv
tests/tb_clock.sv
tests/bp_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module bp_top_tb -o bp_top_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/bp_top_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx '>>> PASS'; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// File: tests/bp_top_tb.sv
////////////////////
// Fetch front end testbench
// Scoreboard of fetch, IF/ID, BHT and BTB
// Directed and random stimulus, concurrent checks
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bp_top_tb;

  import bp_pkg::*;

  localparam int  SEED          = 32'hd8360a85;
  localparam int  RANDOM_CYCLES = 1500;
  localparam int  MAX_CYCLES    = 4000;     // Twice the directed and random length
  localparam pc_t MAIN_PC       = 16'h0010; // Loop branch at index 0 tag 1
  localparam pc_t ALIAS_PC      = 16'h0020; // Index 0 tag 2
  localparam pc_t BACK_PC       = 16'h002e; // Always taken back to 0

  logic clk, rst, enable, is_branch, actual_taken;
  pc_t  actual_target, fetch_pc, redirect_pc, pred_target;
  logic pred_taken, mispredict;
  bp_state_t pred_state;

  logic random_mode, stall_req, alias_on, main_taken;
  pc_t  main_target;
  int   main_count = 0;                     // Resolutions of MAIN_PC
  int   cycle_count = 0;
  int   seen_mispredict = 0;
  int   seen_jump = 0;
  int   seen_clash = 0;
  int   seen_stall = 0;

  tb_clock u_clock (.clk(clk));

  bp_top DUT (
    .clk(clk), .rst(rst), .enable(enable), .is_branch(is_branch),
    .actual_taken(actual_taken), .actual_target(actual_target),
    .fetch_pc(fetch_pc), .redirect_pc(redirect_pc), .pred_taken(pred_taken),
    .mispredict(mispredict), .pred_state(pred_state), .pred_target(pred_target)
  );

  //////////////////// Scoreboard
  logic [BP_ENTRIES-1:0] sb_bht_valid, sb_btb_valid;
  bp_tag_t    sb_bht_tag [BP_ENTRIES];
  logic [1:0] sb_bht_cnt [BP_ENTRIES];
  bp_tag_t    sb_btb_tag [BP_ENTRIES];
  pc_t        sb_btb_tgt [BP_ENTRIES];
  pc_t        sb_fetch_pc, sb_id_pc, sb_id_target;
  logic [1:0] sb_id_state;
  logic       sb_id_taken, sb_bubble;
  bp_idx_t    f_idx, w_idx;
  bp_tag_t    f_tag, w_tag;
  logic [1:0] exp_state;
  logic       exp_taken, exp_mispredict, w_owned;
  pc_t        exp_target, exp_redirect;

  // Saturating counter step with restart at strong not-taken on a tag miss
  function automatic logic [1:0] next_counter(input logic [1:0] prev, input logic taken,
                                              input logic owned);
    if (prev == STRONG_NOT_TAKEN) return taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
    if (!owned) return STRONG_NOT_TAKEN;
    if (taken) return (prev == STRONG_TAKEN) ? prev : prev + 2'd1;
    return prev - 2'd1;
  endfunction

  always_comb begin
    f_idx     = sb_fetch_pc[3:1];           // Halfword bit skipped
    f_tag     = sb_fetch_pc[15:4];
    w_idx     = sb_id_pc[3:1];
    w_tag     = sb_id_pc[15:4];
    exp_state = enable ? sb_bht_cnt[f_idx] : STRONG_NOT_TAKEN;   // Raw counter even on a miss
    exp_taken = sb_bht_valid[f_idx] && (sb_bht_tag[f_idx] == f_tag) && exp_state[1];
    exp_target = (enable && sb_btb_valid[f_idx] && (sb_btb_tag[f_idx] == f_tag)) ?
                 sb_btb_tgt[f_idx] : '0;
    exp_mispredict = is_branch && ((sb_id_taken != actual_taken) ||
                                   (sb_id_taken && (sb_id_target != actual_target)));
    exp_redirect = actual_taken ? actual_target : sb_id_pc + PC_STEP;
    w_owned      = sb_bht_valid[w_idx] && (sb_bht_tag[w_idx] == w_tag);
  end

  always @(posedge clk) begin
    if (rst) begin
      sb_fetch_pc  <= RESET_PC;
      sb_id_pc     <= RESET_PC;
      sb_id_target <= '0;
      sb_id_state  <= STRONG_NOT_TAKEN;
      sb_id_taken  <= 1'b0;
      sb_bubble    <= 1'b0;
      sb_bht_valid <= '0;
      sb_btb_valid <= '0;
      for (int i = 0; i < BP_ENTRIES; i++) begin
        sb_bht_cnt[i] <= STRONG_NOT_TAKEN;
        sb_bht_tag[i] <= '0;
        sb_btb_tag[i] <= '0;
        sb_btb_tgt[i] <= '0;
      end
    end else if (!enable) begin
      if (is_branch) seen_stall <= seen_stall + 1;   // Branch offered while stalled
    end else begin
      if (exp_mispredict) sb_fetch_pc <= exp_redirect;
      else if (exp_taken) sb_fetch_pc <= exp_target;
      else sb_fetch_pc <= sb_fetch_pc + PC_STEP;
      sb_id_pc     <= sb_fetch_pc;
      sb_id_target <= exp_target;
      sb_id_state  <= exp_mispredict ? STRONG_NOT_TAKEN : exp_state;
      sb_id_taken  <= exp_taken && !exp_mispredict;
      sb_bubble    <= exp_mispredict;       // Wrong-path slot
      if (is_branch) begin
        sb_bht_valid[w_idx] <= 1'b1;
        sb_bht_tag[w_idx]   <= w_tag;
        sb_bht_cnt[w_idx]   <= next_counter(sb_id_state, actual_taken, w_owned);
        if (actual_taken) begin
          sb_btb_valid[w_idx] <= 1'b1;
          sb_btb_tag[w_idx]   <= w_tag;
          sb_btb_tgt[w_idx]   <= actual_target;
        end
        if (sb_id_pc == MAIN_PC) main_count <= main_count + 1;
        if (sb_bht_valid[w_idx] && !w_owned) seen_clash <= seen_clash + 1;
      end
      if (exp_mispredict) seen_mispredict <= seen_mispredict + 1;
      if (exp_taken && !exp_mispredict) seen_jump <= seen_jump + 1;
    end
  end

  //////////////////// Failure handling
  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("[ERROR] time %0t %s got %h expected %h", $time, name, got, exp);
    stop_with_failure();
  endtask

  fetch_pc_a : assert property (@(posedge clk) disable iff (rst) fetch_pc == sb_fetch_pc)
    else report_mismatch("fetch_pc", $sampled(fetch_pc), $sampled(sb_fetch_pc));
  pred_taken_a : assert property (@(posedge clk) disable iff (rst) pred_taken == exp_taken)
    else report_mismatch("pred_taken", {15'd0, $sampled(pred_taken)},
                         {15'd0, $sampled(exp_taken)});
  pred_state_a : assert property (@(posedge clk) disable iff (rst) pred_state == exp_state)
    else report_mismatch("pred_state", {14'd0, $sampled(pred_state)},
                         {14'd0, $sampled(exp_state)});
  pred_target_a : assert property (@(posedge clk) disable iff (rst) pred_target == exp_target)
    else report_mismatch("pred_target", $sampled(pred_target), $sampled(exp_target));
  mispredict_a : assert property (@(posedge clk) disable iff (rst)
    mispredict == exp_mispredict)
    else report_mismatch("mispredict", {15'd0, $sampled(mispredict)},
                         {15'd0, $sampled(exp_mispredict)});
  redirect_a : assert property (@(posedge clk) disable iff (rst) redirect_pc == exp_redirect)
    else report_mismatch("redirect_pc", $sampled(redirect_pc), $sampled(exp_redirect));

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d clock cycles, the stimulus never finished", MAX_CYCLES);
      stop_with_failure();
    end
  end

  //////////////////// Stimulus
  function automatic pc_t random_target();
    return pc_t'($urandom() & 32'h0000_003e);   // Even and inside the 64-byte window
  endfunction

  function automatic pc_t home_target(input pc_t pc);
    return (pc * 16'd5 + 16'h000c) & 16'h003e;  // Fixed target per branch PC
  endfunction

  // Decode side of one cycle driven 1 ns after the edge
  task automatic next_cycle();
    logic br;
    logic tk;
    pc_t  tgt;
    @(posedge clk);
    #1;
    br  = 1'b0;
    tk  = 1'b1;
    tgt = '0;
    if (random_mode) begin
      enable = ($urandom_range(9) != 0);  // About one stall in ten
      br  = (sb_id_pc >= 16'h003e) || ($urandom_range(2) == 0);
      tk  = (sb_id_pc >= 16'h003e) || ($urandom_range(3) != 0);
      tgt = ($urandom_range(3) != 0) ? home_target(sb_id_pc) : random_target();
    end else begin
      enable = !stall_req;
      if (sb_id_pc == MAIN_PC) begin
        br  = 1'b1;
        tk  = main_taken;
        tgt = main_target;
      end else if ((alias_on && sb_id_pc == ALIAS_PC) || sb_id_pc == BACK_PC) begin
        br = 1'b1;                          // Taken to address 0
      end
    end
    is_branch     = br && !sb_bubble;       // Bubbles never resolve
    actual_taken  = tk;
    actual_target = tgt;
  endtask

  task automatic wait_main(input int n);
    int goal;
    goal = main_count + n;
    while (main_count < goal) next_cycle();
  endtask

  initial begin
    void'($urandom(SEED));
    rst           = 1'b1;
    enable        = 1'b1;
    is_branch     = 1'b0;
    actual_taken  = 1'b0;
    actual_target = '0;
    random_mode   = 1'b0;
    stall_req     = 1'b0;
    alias_on      = 1'b0;
    main_taken    = 1'b1;
    main_target   = 16'h0004;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_main(4);                           // Learn the loop and then jump on prediction
    main_target = 16'h0006;                 // Wrong target
    wait_main(1);
    main_taken = 1'b0;                      // Wrong direction
    wait_main(1);
    alias_on = 1'b1;                        // Same index with another tag
    while (seen_clash < 2) next_cycle();
    alias_on    = 1'b0;
    main_taken  = 1'b1;
    main_target = 16'h0004;
    wait_main(3);
    while (sb_fetch_pc != MAIN_PC) next_cycle();
    enable    = 1'b0;                       // Stall on a hitting fetch
    is_branch = 1'b0;
    stall_req = 1'b1;
    repeat (3) next_cycle();
    stall_req = 1'b0;
    wait_main(2);
    random_mode = 1'b1;
    repeat (RANDOM_CYCLES) next_cycle();
    if (seen_mispredict > 0 && seen_jump > 0 && seen_clash > 0 && seen_stall > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Stimulus missed a scenario, mispredict %0d jump %0d clash %0d stall %0d",
               seen_mispredict, seen_jump, seen_clash, seen_stall);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
////////////////////
// Testbench clock source
// Free-running clock, 40 ns period
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk                          // Clock to DUT and testbench
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                 // Half of 40 ns
  end

endmodule

`default_nettype wire

// File: hdl/bp_top.sv
////////////////////
// Fetch front end top
// Fetch unit, dynamic predictor and resolver wired together
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bp_top (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  logic              enable,         // Front end running
  input  logic              is_branch,      // Decode sees a branch in IF/ID
  input  logic              actual_taken,   // Its resolved direction
  input  bp_pkg::pc_t       actual_target,  // Its resolved target
  output bp_pkg::pc_t       fetch_pc,       // Current fetch address
  output bp_pkg::pc_t       redirect_pc,    // Correction address
  output logic              pred_taken,     // Fetch PC predicted taken
  output logic              mispredict,     // Flush request
  output bp_pkg::bp_state_t pred_state,     // Counter for the fetch PC
  output bp_pkg::pc_t       pred_target     // Predicted target
);

  import bp_pkg::*;

  //////////////////// IF/ID and strobes
  pc_t       id_pc;
  pc_t       id_pred_target;
  bp_state_t id_state;
  logic      id_pred_taken;
  logic      bht_wen;
  logic      btb_wen;

  fetch_unit u_fetch (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .pred_taken     (pred_taken),
    .mispredict     (mispredict),
    .pred_target    (pred_target),
    .redirect_pc    (redirect_pc),
    .pred_state     (pred_state),
    .fetch_pc       (fetch_pc),
    .id_pc          (id_pc),
    .id_pred_target (id_pred_target),
    .id_state       (id_state),
    .id_pred_taken  (id_pred_taken)
  );

  dynamic_branch_predictor u_dbp (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .fetch_pc      (fetch_pc),
    .id_pc         (id_pc),
    .actual_target (actual_target),
    .id_state      (id_state),
    .bht_wen       (bht_wen),
    .btb_wen       (btb_wen),
    .actual_taken  (actual_taken),
    .pred_taken    (pred_taken),
    .pred_state    (pred_state),
    .pred_target   (pred_target)
  );

  branch_resolver u_resolve (
    .enable         (enable),
    .is_branch      (is_branch),
    .actual_taken   (actual_taken),
    .id_pred_taken  (id_pred_taken),
    .id_pc          (id_pc),
    .id_pred_target (id_pred_target),
    .actual_target  (actual_target),
    .bht_wen        (bht_wen),
    .btb_wen        (btb_wen),
    .mispredict     (mispredict),
    .redirect_pc    (redirect_pc)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
////////////////////
// Fetch unit
// PC register with next-PC priority, IF/ID register
// with bubble insertion on a mispredict
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  logic              enable,         // Low stalls PC and IF/ID
  input  logic              pred_taken,     // Predictor says jump
  input  logic              mispredict,     // Resolver says flush
  input  bp_pkg::pc_t       pred_target,    // Predicted target
  input  bp_pkg::pc_t       redirect_pc,    // Corrected fetch address
  input  bp_pkg::bp_state_t pred_state,     // Counter for the fetch PC
  output bp_pkg::pc_t       fetch_pc,       // Current fetch address
  output bp_pkg::pc_t       id_pc,          // IF/ID address
  output bp_pkg::pc_t       id_pred_target, // IF/ID predicted target
  output bp_pkg::bp_state_t id_state,       // IF/ID predicted counter
  output logic              id_pred_taken   // IF/ID predicted direction
);

  import bp_pkg::*;

  pc_t next_pc;                             // PC for the next edge

  //////////////////// Next PC
  always_comb begin
    if (mispredict) begin
      next_pc = redirect_pc;                // Correction wins
    end else if (pred_taken) begin
      next_pc = pred_target;                // Follow the BTB
    end else begin
      next_pc = fetch_pc + PC_STEP;         // Sequential
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc <= RESET_PC;
    end else if (enable) begin
      fetch_pc <= next_pc;
    end
  end

  //////////////////// IF/ID
  always_ff @(posedge clk) begin
    if (rst) begin
      id_pc          <= RESET_PC;
      id_pred_target <= '0;
      id_state       <= STRONG_NOT_TAKEN;
      id_pred_taken  <= 1'b0;
    end else if (enable) begin
      id_pc          <= fetch_pc;
      id_pred_target <= pred_target;
      if (mispredict) begin
        // Wrong-path fetch becomes a bubble
        id_state      <= STRONG_NOT_TAKEN;
        id_pred_taken <= 1'b0;
      end else begin
        id_state      <= pred_state;
        id_pred_taken <= pred_taken;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/branch_resolver.sv
////////////////////
// Branch resolver
// Compares IF/ID prediction with the decoded outcome,
// drives table strobes, mispredict and redirect PC
////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
  input  logic        enable,               // Front end running
  input  logic        is_branch,            // IF/ID holds a branch
  input  logic        actual_taken,         // Resolved direction
  input  logic        id_pred_taken,        // Direction predicted at fetch
  input  bp_pkg::pc_t id_pc,                // Address of the branch
  input  bp_pkg::pc_t id_pred_target,       // Target predicted at fetch
  input  bp_pkg::pc_t actual_target,        // Resolved target
  output logic        bht_wen,              // Update counter
  output logic        btb_wen,              // Update target
  output logic        mispredict,           // Flush and redirect fetch
  output bp_pkg::pc_t redirect_pc           // Correct next fetch address
);

  import bp_pkg::*;

  logic dir_miss;                           // Direction was wrong
  logic tgt_miss;                           // Taken guess, wrong target
  pc_t  fall_through;                       // Sequential successor

  //////////////////// Table strobes
  assign bht_wen = enable && is_branch;                   // Every resolved branch
  assign btb_wen = enable && is_branch && actual_taken;   // Only taken ones have a target

  //////////////////// Misprediction
  assign dir_miss   = (id_pred_taken != actual_taken);
  assign tgt_miss   = id_pred_taken && (id_pred_target != actual_target);
  assign mispredict = is_branch && (dir_miss || tgt_miss);

  // Not-taken branch resumes right after itself
  assign fall_through = id_pc + PC_STEP;
  assign redirect_pc  = actual_taken ? actual_target : fall_through;

  // Non-branch slots and bubbles must never flush the front end
  always_comb begin
    mispredict_branch_a : assert #0 (!mispredict || is_branch)
      else $error("mispredict raised without a branch in IF/ID");
  end

endmodule

`default_nettype wire

// File: hdl/dynamic_branch_predictor.sv
////////////////////
// Dynamic branch predictor
// BHT plus BTB, taken decision and target for the fetch PC
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dynamic_branch_predictor (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  logic              enable,         // Front end running
  input  bp_pkg::pc_t       fetch_pc,       // Address being fetched
  input  bp_pkg::pc_t       id_pc,          // Address of the branch in IF/ID
  input  bp_pkg::pc_t       actual_target,  // Resolved target from decode
  input  bp_pkg::bp_state_t id_state,       // Counter predicted for id_pc
  input  logic              bht_wen,        // BHT update strobe
  input  logic              btb_wen,        // BTB update strobe
  input  logic              actual_taken,   // Resolved direction
  output logic              pred_taken,     // Fetch PC predicted taken
  output bp_pkg::bp_state_t pred_state,     // Counter for the fetch PC
  output bp_pkg::pc_t       pred_target     // Predicted target
);

  import bp_pkg::*;

  bp_state_t bht_state;                     // Raw counter read
  logic      bht_hit;                       // BHT tag hit
  pc_t       btb_target;                    // Raw target read
  logic      btb_hit;                       // BTB tag hit

  branch_history_table u_bht (
    .clk           (clk),
    .rst           (rst),
    .rd_pc         (fetch_pc),
    .wr_pc         (id_pc),
    .wr_en         (bht_wen),
    .actual_taken  (actual_taken),
    .wr_prev_state (id_state),
    .rd_state      (bht_state),
    .rd_hit        (bht_hit)
  );

  branch_target_buffer u_btb (
    .clk       (clk),
    .rst       (rst),
    .rd_pc     (fetch_pc),
    .wr_pc     (id_pc),
    .wr_target (actual_target),
    .wr_en     (btb_wen),
    .rd_target (btb_target),
    .rd_hit    (btb_hit)
  );

  //////////////////// Outputs
  assign pred_state  = enable ? bht_state : STRONG_NOT_TAKEN;   // Zero while stalled
  assign pred_target = (enable && btb_hit) ? btb_target : '0;   // Miss gives no target
  assign pred_taken  = bht_hit && pred_state[1];                // Counter bit 1 is direction

endmodule

`default_nettype wire

// File: hdl/branch_target_buffer.sv
////////////////////
// Branch target buffer
// 8 tagged targets, combinational read, registered write
////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
  input  logic        clk,                  // System clock
  input  logic        rst,                  // Sync reset, active high
  input  bp_pkg::pc_t rd_pc,                // Fetch address to look up
  input  bp_pkg::pc_t wr_pc,                // Address of the taken branch
  input  bp_pkg::pc_t wr_target,            // Resolved target
  input  logic        wr_en,                // Write strobe, taken branches only
  output bp_pkg::pc_t rd_target,            // Target of the indexed entry
  output logic        rd_hit                // Entry valid and tag equal
);

  import bp_pkg::*;

  logic [BP_ENTRIES-1:0] valid;             // One valid bit per entry
  bp_tag_t tag_mem [BP_ENTRIES];            // Stored PC tags
  pc_t     tgt_mem [BP_ENTRIES];            // Stored targets

  bp_idx_t rd_idx;
  bp_idx_t wr_idx;

  assign rd_idx = pc_idx(rd_pc);
  assign wr_idx = pc_idx(wr_pc);

  //////////////////// Lookup
  assign rd_target = tgt_mem[rd_idx];
  assign rd_hit    = valid[rd_idx] && (tag_mem[rd_idx] == pc_tag(rd_pc));

  //////////////////// Registered write
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      for (int i = 0; i < BP_ENTRIES; i++) begin
        tgt_mem[i] <= '0;                   // Zero target out of reset
      end
    end else if (wr_en) begin
      valid[wr_idx]   <= 1'b1;
      tgt_mem[wr_idx] <= wr_target;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx] <= pc_tag(wr_pc);
    end
  end

  // Decode hands over halfword-aligned targets only
  wr_target_even_a : assert property (@(posedge clk) disable iff (rst)
    wr_en |-> (wr_target[0] == 1'b0))
    else $error("BTB write with odd target %h", wr_target);

endmodule

`default_nettype wire

// File: hdl/branch_history_table.sv
////////////////////
// Branch history table
// 8 tagged 2-bit saturating counters, combinational read,
// registered update with the next-counter rule
////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_history_table (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  bp_pkg::pc_t       rd_pc,          // Fetch address to look up
  input  bp_pkg::pc_t       wr_pc,          // Address of the resolved branch
  input  logic              wr_en,          // Update strobe from resolver
  input  logic              actual_taken,   // Resolved direction
  input  bp_pkg::bp_state_t wr_prev_state,  // Counter value that was predicted
  output bp_pkg::bp_state_t rd_state,       // Counter of the indexed entry
  output logic              rd_hit          // Entry valid and tag equal
);

  import bp_pkg::*;

  //////////////////// Storage
  logic [BP_ENTRIES-1:0] valid;             // One valid bit per entry
  bp_tag_t   tag_mem [BP_ENTRIES];          // Stored PC tags
  bp_state_t cnt_mem [BP_ENTRIES];          // Saturating counters

  bp_idx_t   rd_idx;                        // Read side index
  bp_tag_t   rd_tag;                        // Read side tag
  bp_idx_t   wr_idx;                        // Write side index
  bp_tag_t   wr_tag;                        // Write side tag
  logic      wr_match;                      // Write address already owns the entry
  bp_state_t next_state;                    // Counter value to store

  assign rd_idx = pc_idx(rd_pc);
  assign rd_tag = pc_tag(rd_pc);
  assign wr_idx = pc_idx(wr_pc);
  assign wr_tag = pc_tag(wr_pc);

  //////////////////// Lookup
  assign rd_state = cnt_mem[rd_idx];        // Raw counter, even on a tag miss
  assign rd_hit   = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign wr_match = valid[wr_idx] && (tag_mem[wr_idx] == wr_tag);

  //////////////////// Counter update
  // Starts from the predicted value, not the current table contents
  always_comb begin
    next_state = STRONG_NOT_TAKEN;          // Default and tag-miss value
    case (wr_prev_state)
      STRONG_NOT_TAKEN: begin
        next_state = actual_taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
      end
      WEAK_NOT_TAKEN: begin
        if (wr_match) begin
          next_state = actual_taken ? WEAK_TAKEN : STRONG_NOT_TAKEN;
        end
      end
      WEAK_TAKEN: begin
        if (wr_match) begin
          next_state = actual_taken ? STRONG_TAKEN : WEAK_NOT_TAKEN;
        end
      end
      STRONG_TAKEN: begin
        if (wr_match) begin
          next_state = actual_taken ? STRONG_TAKEN : WEAK_TAKEN;
        end
      end
      default: begin
        next_state = STRONG_NOT_TAKEN;      // Unknown predicted value
      end
    endcase
  end

  //////////////////// Registered write
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;                          // All entries empty
      for (int i = 0; i < BP_ENTRIES; i++) begin
        cnt_mem[i] <= STRONG_NOT_TAKEN;
      end
    end else if (wr_en) begin
      valid[wr_idx]   <= 1'b1;              // Entry now owned by wr_pc
      cnt_mem[wr_idx] <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx] <= wr_tag;            // Meaningless until valid is set
    end
  end

  // Predicted state travels through IF/ID, so it must be clean at resolve
  wr_state_known_a : assert property (@(posedge clk) disable iff (rst)
    wr_en |-> !$isunknown(wr_prev_state))
    else $error("BHT update with unknown predicted state");

endmodule

`default_nettype wire

// File: hdl/bp_pkg.sv
////////////////////
// Branch prediction package
// Widths, PC and counter typedefs, table geometry
// and the index/tag split of a fetch address
////////////////////

`default_nettype none

package bp_pkg;

  //////////////////// Widths and geometry
  localparam int PC_W       = 16;            // Instruction address width
  localparam int BP_ENTRIES = 8;             // Entries per table
  localparam int BP_IDX_W   = 3;             // log2 of BP_ENTRIES
  localparam int BP_TAG_LSB = 4;             // Lowest PC bit in the tag
  localparam int BP_TAG_W   = PC_W - BP_TAG_LSB;

  typedef logic [PC_W-1:0]     pc_t;         // Byte address, bit 0 always zero
  typedef logic [BP_IDX_W-1:0] bp_idx_t;     // Table index, PC[3:1]
  typedef logic [BP_TAG_W-1:0] bp_tag_t;     // Table tag, PC[15:4]

  localparam pc_t PC_STEP  = 16'd2;          // 2-byte instructions
  localparam pc_t RESET_PC = 16'h0000;       // First fetch address

  // 2-bit saturating counter, bit 1 is the direction
  typedef enum logic [1:0] {
    STRONG_NOT_TAKEN = 2'b00,
    WEAK_NOT_TAKEN   = 2'b01,
    WEAK_TAKEN       = 2'b10,
    STRONG_TAKEN     = 2'b11
  } bp_state_t;

  //////////////////// Address split
  function automatic bp_idx_t pc_idx(input pc_t pc);
    return pc[BP_IDX_W:1];                   // Skip the halfword bit
  endfunction

  function automatic bp_tag_t pc_tag(input pc_t pc);
    return pc[PC_W-1:BP_TAG_LSB];            // Upper bits above the index
  endfunction

endpackage

`default_nettype wire
